//--- files.f
hdl/video_pkg.sv
hdl/mem_pkg.sv
hdl/mem_bus_if.sv
hdl/pixel_packer.sv
hdl/frame_ram.sv
hdl/pixel_unpacker.sv
hdl/frame_store_top.sv
verif/frame_store_tb.sv

//--- hdl/frame_ram.sv
module frame_ram (
    input  logic   mm_tras_inst,
    input  logic   reset,
    mem_bus_if.ram bus
);

    import mem_pkg::*;

    // One frame of words, raw bits
    logic [WORD_W-1:0] mem [FRAME_WORDS];

    // Write port
    always_ff @(posedge mm_tras_inst) begin
        if (bus.wr_en) begin
            mem[bus.wr_addr] <= bus.wr_data.raw;
        end
    end

    // Read port, registered output
    always_ff @(posedge mm_tras_inst) begin
        if (bus.rd_en) begin
            bus.rd_data.raw <= mem[bus.rd_addr];
        end
    end

    // Valid follows the request by one cycle
    always_ff @(posedge mm_tras_inst) begin
        if (reset) begin
            bus.rd_valid <= 1'b0;
        end else begin
            bus.rd_valid <= bus.rd_en;
        end
    end

    // Read requests are single-cycle strobes, so every valid carries its own word
    a_rd_latency : assert property (
        @(posedge mm_tras_inst) disable iff (reset)
        bus.rd_en |=> !bus.rd_en
    );

endmodule

//--- hdl/frame_store_top.sv
module frame_store_top (
    input  logic              mm_tras_inst,
    input  logic              reset,
    input  logic              in_vsync,
    input  logic              in_de,
    input  video_pkg::pixel_t in_pixel,
    input  logic              rd_start,
    output logic              out_valid,
    output video_pkg::pixel_t out_pixel,
    output logic              out_sof
);

    // Word bus shared by packer, memory and unpacker
    mem_bus_if u_bus (
        .mm_tras_inst (mm_tras_inst)
    );

    // Video in, eight pixels per word
    pixel_packer u_pixel_packer (
        .mm_tras_inst (mm_tras_inst),
        .reset        (reset),
        .in_vsync     (in_vsync),
        .in_de        (in_de),
        .in_pixel     (in_pixel),
        .bus          (u_bus.packer)
    );

    // Frame memory, separate write and read ports
    frame_ram u_frame_ram (
        .mm_tras_inst (mm_tras_inst),
        .reset        (reset),
        .bus          (u_bus.ram)
    );

    // Read back and unpack
    pixel_unpacker u_pixel_unpacker (
        .mm_tras_inst (mm_tras_inst),
        .reset        (reset),
        .rd_start     (rd_start),
        .bus          (u_bus.unpacker),
        .out_valid    (out_valid),
        .out_pixel    (out_pixel),
        .out_sof      (out_sof)
    );

endmodule

//--- hdl/mem_bus_if.sv
interface mem_bus_if (
    input logic mm_tras_inst
);

    import mem_pkg::*;

    // Write side, single-cycle strobe
    logic       wr_en;
    word_addr_t wr_addr;
    mem_word_u  wr_data;

    // Read side, data returns one cycle after the request
    logic       rd_en;
    word_addr_t rd_addr;
    mem_word_u  rd_data;
    logic       rd_valid;

    // Pixel packer, write requests only
    modport packer (
        input  mm_tras_inst,
        output wr_en,
        output wr_addr,
        output wr_data
    );

    // Pixel unpacker, read requests and returned words
    modport unpacker (
        input  mm_tras_inst,
        output rd_en,
        output rd_addr,
        input  rd_data,
        input  rd_valid
    );

    // Frame memory, serves both ports
    modport ram (
        input  mm_tras_inst,
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_en,
        input  rd_addr,
        output rd_data,
        output rd_valid
    );

endinterface

//--- hdl/mem_pkg.sv
package mem_pkg;

    import video_pkg::*;

    // Pixel lanes packed into one memory word
    localparam int LANES = 8;

    // Word width, eight pixels side by side
    localparam int WORD_W = PIX_W * LANES;

    // Whole frame in words
    localparam int FRAME_WORDS = FRAME_PIX / LANES;

    // Word address and lane index widths
    localparam int ADDR_W = $clog2(FRAME_WORDS);
    localparam int LANE_W = $clog2(LANES);

    typedef logic [ADDR_W-1:0] word_addr_t;
    typedef logic [LANE_W-1:0] lane_idx_t;

    // One memory word, seen as raw storage bits or as pixel lanes
    // Lane 0 is the earliest pixel, sitting in the low bits
    typedef union packed {
        logic [WORD_W-1:0]     raw;
        pixel_t [LANES-1:0]    lane;
    } mem_word_u;

endpackage

//--- hdl/pixel_packer.sv
module pixel_packer (
    input  logic              mm_tras_inst,
    input  logic              reset,
    input  logic              in_vsync,
    input  logic              in_de,
    input  video_pkg::pixel_t in_pixel,
    mem_bus_if.packer         bus
);

    import mem_pkg::*;

    // Lane being filled next
    lane_idx_t  lane_cnt;
    // Address of the word under assembly
    word_addr_t wr_ptr;
    // Whole frame already stored
    logic       frame_full;

    // Word under assembly and its next value
    mem_word_u  asm_word;
    mem_word_u  asm_next;

    logic       pix_take;
    logic       word_done;

    // Pixel accepted only outside vsync and before the frame fills up
    assign pix_take  = in_de && !in_vsync && !frame_full;
    assign word_done = pix_take && (lane_cnt == lane_idx_t'(LANES - 1));

    // Drop the incoming pixel into its lane
    always_comb begin
        asm_next = asm_word;
        asm_next.lane[lane_cnt] = in_pixel;
    end

    // Lane count, frame address and full flag
    always_ff @(posedge mm_tras_inst) begin
        if (reset) begin
            lane_cnt   <= '0;
            wr_ptr     <= '0;
            frame_full <= 1'b0;
        end else if (in_vsync) begin
            // New frame, an unfinished word is thrown away
            lane_cnt   <= '0;
            wr_ptr     <= '0;
            frame_full <= 1'b0;
        end else if (pix_take) begin
            lane_cnt <= lane_cnt + 1'b1;
            if (word_done) begin
                if (wr_ptr == word_addr_t'(FRAME_WORDS - 1)) begin
                    // Last word of the frame, hold the pointer
                    frame_full <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    // Assembly register
    always_ff @(posedge mm_tras_inst) begin
        if (pix_take) begin
            asm_word <= asm_next;
        end
    end

    // Write strobe one cycle after the eighth pixel
    always_ff @(posedge mm_tras_inst) begin
        if (reset) begin
            bus.wr_en   <= 1'b0;
            bus.wr_addr <= '0;
        end else begin
            bus.wr_en <= word_done;
            if (word_done) begin
                bus.wr_addr <= wr_ptr;
            end
        end
    end

    // Write data, complete word including the eighth lane
    always_ff @(posedge mm_tras_inst) begin
        if (word_done) begin
            bus.wr_data <= asm_next;
        end
    end

    // Writes walk the frame one word at a time and never go past its last word
    a_wr_in_frame : assert property (
        @(posedge mm_tras_inst) disable iff (reset)
        bus.wr_en |-> (bus.wr_addr == '0) ||
                      (int'(bus.wr_addr) == int'($past(bus.wr_addr)) + 1)
    );

endmodule

//--- hdl/pixel_unpacker.sv
module pixel_unpacker (
    input  logic              mm_tras_inst,
    input  logic              reset,
    input  logic              rd_start,
    mem_bus_if.unpacker       bus,
    output logic              out_valid,
    output video_pkg::pixel_t out_pixel,
    output logic              out_sof
);

    import mem_pkg::*;

    // Read sequencing
    logic       busy;
    word_addr_t word_cnt;
    lane_idx_t  phase;
    logic       last_word;
    logic       done;

    // Output side
    mem_word_u  lane_buf;
    lane_idx_t  out_lane;
    logic       sof_pend;

    assign last_word = (word_cnt == word_addr_t'(FRAME_WORDS - 1));

    // Last pixel of the frame leaving, phase has wrapped with no request out
    assign done = busy && last_word && (phase == '0) && !bus.rd_en;

    // Request side
    always_ff @(posedge mm_tras_inst) begin
        if (reset) begin
            busy        <= 1'b0;
            word_cnt    <= '0;
            phase       <= '0;
            bus.rd_en   <= 1'b0;
            bus.rd_addr <= '0;
        end else begin
            bus.rd_en <= 1'b0;
            if (!busy) begin
                // Start ignored while a read is in progress
                if (rd_start) begin
                    busy        <= 1'b1;
                    word_cnt    <= '0;
                    phase       <= '0;
                    bus.rd_en   <= 1'b1;
                    bus.rd_addr <= '0;
                end
            end else if (done) begin
                busy <= 1'b0;
            end else begin
                phase <= phase + 1'b1;
                // Next word requested so it lands right after the last lane
                if (phase == lane_idx_t'(LANES - 1) && !last_word) begin
                    word_cnt    <= word_cnt + 1'b1;
                    bus.rd_en   <= 1'b1;
                    bus.rd_addr <= word_cnt + 1'b1;
                end
            end
        end
    end

    // Lane counter, lane 0 goes out straight from the read data
    always_ff @(posedge mm_tras_inst) begin
        if (reset) begin
            out_lane <= '0;
        end else if (bus.rd_valid) begin
            out_lane <= lane_idx_t'(1);
        end else if (out_lane != '0) begin
            // Wraps back to idle after lane 7
            out_lane <= out_lane + 1'b1;
        end
    end

    // Start of frame marker waits for the first word
    always_ff @(posedge mm_tras_inst) begin
        if (reset) begin
            sof_pend <= 1'b0;
        end else if (!busy && rd_start) begin
            sof_pend <= 1'b1;
        end else if (bus.rd_valid) begin
            sof_pend <= 1'b0;
        end
    end

    // Lane buffer, holds lanes 1 to 7
    always_ff @(posedge mm_tras_inst) begin
        if (bus.rd_valid) begin
            lane_buf <= bus.rd_data;
        end
    end

    // Pixel out
    assign out_valid = bus.rd_valid || (out_lane != '0);
    assign out_pixel = bus.rd_valid ? bus.rd_data.lane[0] : lane_buf.lane[out_lane];
    assign out_sof   = bus.rd_valid && sof_pend;

    // Pixels leave only while a read is active, busy drops after the last lane
    a_rd_in_busy : assert property (
        @(posedge mm_tras_inst) disable iff (reset)
        out_valid |-> busy
    );

endmodule

//--- hdl/video_pkg.sv
package video_pkg;

    // Pixel geometry
    localparam int PIX_W = 32;

    // Frame geometry, active region only
    localparam int FRAME_W = 64;
    localparam int FRAME_H = 4;

    // Pixels per frame
    localparam int FRAME_PIX = FRAME_W * FRAME_H;

    // One pixel as it arrives on the video input
    typedef logic [PIX_W-1:0] pixel_t;

endpackage

//--- run.sh
#!/bin/sh
# Build and run the frame store testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module frame_store_tb \
    -o frame_store_sim && ./obj_dir/frame_store_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "no passing result in log"; exit 1; }
echo "simulation passed"

//--- verif/frame_store_tb.sv
module frame_store_tb;

    import video_pkg::*;
    import mem_pkg::*;

    // Bench timing and limits
    localparam int CLK_PERIOD    = 100;
    localparam int LINE_GAP      = 6;
    localparam int SETTLE_CYCLES = 4;
    localparam int IDLE_TIMEOUT  = 600;
    localparam int READ_TIMEOUT  = FRAME_PIX + 64;
    localparam int QUIET_CYCLES  = 16;

    logic   mm_tras_inst;
    logic   reset;
    logic   in_vsync;
    logic   in_de;
    pixel_t in_pixel;
    logic   rd_start;
    logic   out_valid;
    pixel_t out_pixel;
    logic   out_sof;

    // Error tallies
    int check_errors   = 0;
    int timeout_errors = 0;
    int other_errors   = 0;

    // Pixel source state
    logic [31:0] rng_state = 32'hced6_71f8;

    // Model of the stored frame, whole words only
    pixel_t model_words [FRAME_WORDS][LANES];
    pixel_t pend_lanes [LANES];
    int     pend_cnt   = 0;
    int     word_ptr   = 0;
    bit     model_full = 1'b0;

    // Read-back bookkeeping shared with the compare process
    int rx_idx      = 0;
    bit read_issued = 1'b0;

    frame_store_top u_frame_store_top (
        .mm_tras_inst (mm_tras_inst),
        .reset        (reset),
        .in_vsync     (in_vsync),
        .in_de        (in_de),
        .in_pixel     (in_pixel),
        .rd_start     (rd_start),
        .out_valid    (out_valid),
        .out_pixel    (out_pixel),
        .out_sof      (out_sof)
    );

    initial begin
        mm_tras_inst = 1'b0;
        forever #(CLK_PERIOD / 2) mm_tras_inst = ~mm_tras_inst;
    end

    // 32-bit xorshift, shifts 13, 17, 5
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected pixel at position idx of the read-back
    function automatic pixel_t expected_pixel(input int idx);
        return model_words[idx / LANES][idx % LANES];
    endfunction

    // New frame, partial word and address dropped
    task automatic model_vsync();
        pend_cnt   = 0;
        word_ptr   = 0;
        model_full = 1'b0;
    endtask

    // One accepted pixel; a word lands only once all lanes are filled
    task automatic model_pixel(input pixel_t p);
        if (!model_full) begin
            pend_lanes[pend_cnt] = p;
            pend_cnt++;
            if (pend_cnt == LANES) begin
                for (int l = 0; l < LANES; l++) begin
                    model_words[word_ptr][l] = pend_lanes[l];
                end
                pend_cnt = 0;
                // Frame full, rest ignored until vsync
                if (word_ptr == FRAME_WORDS - 1) begin
                    model_full = 1'b1;
                end else begin
                    word_ptr++;
                end
            end
        end
    endtask

    task automatic check_value(input string name, input pixel_t actual, input pixel_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            check_errors++;
        end
    endtask

    // One-cycle vsync pulse
    task automatic drive_vsync();
        @(negedge mm_tras_inst);
        in_vsync = 1'b1;
        model_vsync();
        @(negedge mm_tras_inst);
        in_vsync = 1'b0;
        repeat (LINE_GAP - 1) @(negedge mm_tras_inst);
    endtask

    // Vsync, then lines of FRAME_W pixels until npix are sent
    task automatic drive_frame(input int npix);
        int sent;
        int col;
        sent = 0;
        drive_vsync();
        while (sent < npix) begin
            col = 0;
            while (col < FRAME_W && sent < npix) begin
                @(negedge mm_tras_inst);
                rng_state = xorshift32(rng_state);
                in_de     = 1'b1;
                in_pixel  = rng_state;
                model_pixel(rng_state);
                col++;
                sent++;
            end
            // Horizontal blank
            @(negedge mm_tras_inst);
            in_de    = 1'b0;
            in_pixel = '0;
            repeat (LINE_GAP - 1) @(negedge mm_tras_inst);
        end
        // Last word write drains
        repeat (SETTLE_CYCLES) @(negedge mm_tras_inst);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (out_valid !== 1'b0 && waited < IDLE_TIMEOUT) begin
            @(negedge mm_tras_inst);
            waited++;
        end
        if (out_valid !== 1'b0) begin
            $display("TIMEOUT at %0t: output stream did not go idle within %0d cycles",
                     $time, IDLE_TIMEOUT);
            timeout_errors++;
        end
    endtask

    // Frame read; extra_starts pulses rd_start again while the read runs
    task automatic read_frame(input int extra_starts);
        int high_cycles;
        int waited;
        int pulses;
        high_cycles = 0;
        waited      = 0;
        pulses      = 0;
        wait_idle();
        rx_idx = 0;
        @(negedge mm_tras_inst);
        rd_start    = 1'b1;
        read_issued = 1'b1;
        // One cycle in, memory request only
        @(negedge mm_tras_inst);
        rd_start = (extra_starts > 0);
        if (extra_starts > 0) begin
            pulses++;
        end
        check_value("out_valid", pixel_t'(out_valid), pixel_t'(0));
        // Two cycles in, first pixel
        @(negedge mm_tras_inst);
        rd_start = 1'b0;
        check_value("out_valid", pixel_t'(out_valid), pixel_t'(1));
        while (out_valid === 1'b1 && waited < READ_TIMEOUT) begin
            high_cycles++;
            @(negedge mm_tras_inst);
            waited++;
            if (pulses < extra_starts && high_cycles % 64 == 5) begin
                rd_start = 1'b1;
                pulses++;
            end else begin
                rd_start = 1'b0;
            end
        end
        rd_start = 1'b0;
        if (out_valid === 1'b1) begin
            $display("TIMEOUT at %0t: read stream still running after %0d cycles",
                     $time, READ_TIMEOUT);
            timeout_errors++;
        end
        check_value("out_valid_run", pixel_t'(high_cycles), pixel_t'(FRAME_PIX));
        // No restart, no trailing pixels
        repeat (QUIET_CYCLES) begin
            @(negedge mm_tras_inst);
            check_value("out_valid", pixel_t'(out_valid), pixel_t'(0));
        end
        check_value("pixel_count", pixel_t'(rx_idx), pixel_t'(FRAME_PIX));
    endtask

    // Compare process, outputs settled since the rising edge
    always @(negedge mm_tras_inst) begin
        if (!reset) begin
            if (!read_issued) begin
                check_value("out_valid", pixel_t'(out_valid), pixel_t'(0));
                check_value("out_sof", pixel_t'(out_sof), pixel_t'(0));
            end else if (out_valid === 1'b1) begin
                if (rx_idx >= FRAME_PIX) begin
                    $display("ERROR at %0t: pixel delivered after the end of the frame", $time);
                    other_errors++;
                end else begin
                    check_value("out_pixel", out_pixel, expected_pixel(rx_idx));
                    check_value("out_sof", pixel_t'(out_sof), pixel_t'(rx_idx == 0));
                end
                rx_idx++;
            end else begin
                check_value("out_sof", pixel_t'(out_sof), pixel_t'(0));
            end
        end
    end

    initial begin
        reset    = 1'b1;
        in_vsync = 1'b0;
        in_de    = 1'b0;
        in_pixel = '0;
        rd_start = 1'b0;
        repeat (3) @(posedge mm_tras_inst);
        @(negedge mm_tras_inst);
        reset = 1'b0;

        // Quiet after reset
        repeat (10) @(negedge mm_tras_inst);

        // Full frame, read back in order
        drive_frame(FRAME_PIX);
        read_frame(0);

        // New frame replaces the old one
        drive_frame(FRAME_PIX);
        read_frame(0);

        // Cut-off frame of 8k+3 pixels, then a full one
        drive_frame(5 * LANES + 3);
        drive_frame(FRAME_PIX);
        read_frame(0);

        // Start pulses during a running read
        read_frame(3);

        // Overlong frame, tail dropped
        drive_frame(FRAME_PIX + 20);
        read_frame(0);

        $display("errors: %0d check, %0d timeout, %0d other",
                 check_errors, timeout_errors, other_errors);
        if (check_errors + timeout_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
